// File: source/axis2axi_settings.svh
// Build-time settings for the AXI read bridge
// Included by the packages and by every RTL module
`ifndef AXIS2AXI_SETTINGS_SVH
`define AXIS2AXI_SETTINGS_SVH

// Byte address width of the AXI read port
`define AXI_ADDR_W 16

// Log2 of the longest burst in beats
`define BURST_W 3

// Log2 of the stream buffer depth in words
`define BUF_DEPTH_W 4

// Consumer credit counter width
`define CREDIT_W 5

`endif

// File: source/axi_rd_pkg.sv
// AXI4 read channel types and the fixed AR attributes of the bridge
// Imported by the engine and the top level
`include "axis2axi_settings.svh"

package axi_rd_pkg;

   typedef enum logic [1:0] {
      BURST_FIXED = 2'd0,
      BURST_INCR  = 2'd1,
      BURST_WRAP  = 2'd2
   } axi_burst_e;

   // Read address channel
   typedef struct packed {
      logic [`AXI_ADDR_W-1:0] addr;
      logic [7:0]             len;
      logic [2:0]             size;
      axi_burst_e             burst;
      logic [0:0]             id;
      logic [3:0]             cache;
      logic [2:0]             prot;
   } axi_ar_t;

   // Read data channel with the response left unchecked
   typedef struct packed {
      logic [31:0] data;
      logic        last;
      logic [1:0]  resp;
   } axi_r_t;

   // Only 4 byte beats
   localparam logic [2:0] AR_SIZE_4B    = 3'd2;
   localparam axi_burst_e AR_BURST_INCR = BURST_INCR;
   // Modifiable, non-bufferable
   localparam logic [3:0] AR_CACHE_DEF  = 4'b0010;
   localparam logic [2:0] AR_PROT_DEF   = 3'b010;

endpackage

// File: source/axis2axi_pkg.sv
// Bridge-side types: config request, stream word and engine states
// Imported by the engine, the stream buffer and the top level
`include "axis2axi_settings.svh"

package axis2axi_pkg;

   // Start byte address and length in 32-bit words
   typedef struct packed {
      logic [`AXI_ADDR_W-1:0] addr;
      logic [`AXI_ADDR_W-1:0] len;
   } cfg_req_t;

   // Last marks the final word of a request
   typedef struct packed {
      logic [31:0] data;
      logic        last;
   } stream_word_t;

   // Read engine states
   typedef enum logic [1:0] {
      IDLE = 2'd0,
      PLAN = 2'd1,
      ADDR = 2'd2,
      DATA = 2'd3
   } eng_state_e;

endpackage

// File: source/axis2axi_burst_calc.sv
// Picks the length of the next AXI read burst
// Bounded by the remaining words, the maximum burst and the 4 KB page
`timescale 1ns/1ns
`include "axis2axi_settings.svh"

module axis2axi_burst_calc (
   input  logic [`AXI_ADDR_W-1:0] remain_i,
   input  logic [`AXI_ADDR_W-1:0] addr_i,
   output logic [`BURST_W:0]      burst_len_o
);

   localparam int unsigned MAX_BURST = 2 ** `BURST_W;

   logic [`BURST_W:0] size_len;

   // Full burst unless the request tail is shorter
   always_comb begin
      if (remain_i >= MAX_BURST) begin
         size_len = MAX_BURST[`BURST_W:0];
      end else begin
         size_len = remain_i[`BURST_W:0];
      end
   end

   generate
      if (`AXI_ADDR_W >= 13) begin : g_page_clamp
         logic [12:0] page_words;

         // Words left before the next 4 KB page
         assign page_words = (13'h1000 - {1'b0, addr_i[11:0]}) >> 2;

         always_comb begin
            if (page_words < size_len) begin
               burst_len_o = page_words[`BURST_W:0];
            end else begin
               burst_len_o = size_len;
            end
         end
      end else begin : g_no_clamp
         // Address space smaller than one page
         assign burst_len_o = size_len;
      end
   endgenerate

endmodule

// File: source/axis2axi_rd_engine.sv
// Burst-issuing engine of the read bridge
// Takes a config request, issues AR bursts one at a time and forwards R beats
`timescale 1ns/1ns
`include "axis2axi_settings.svh"

module axis2axi_rd_engine
   import axi_rd_pkg::*;
   import axis2axi_pkg::*;
(
   input  logic                      clk_i,
   input  logic                      rst_n_i,
   // Config request
   input  logic                      cfg_valid_i,
   input  cfg_req_t                  cfg_i,
   output logic                      cfg_ready_o,
   // Burst calculator
   input  logic [`BURST_W:0]         burst_len_i,
   output logic [`AXI_ADDR_W-1:0]    remain_o,
   output logic [`AXI_ADDR_W-1:0]    addr_o,
   // Stream buffer room
   input  logic [`BUF_DEPTH_W:0]     free_cnt_i,
   // AXI read address
   output axi_ar_t                   ar_o,
   output logic                      ar_valid_o,
   input  logic                      ar_ready_i,
   // AXI read data
   input  axi_r_t                    r_i,
   input  logic                      r_valid_i,
   output logic                      r_ready_o,
   // Stream buffer push
   output logic                      push_o,
   output stream_word_t              push_word_o
);

   eng_state_e state_q;
   eng_state_e state_d;

   logic [`AXI_ADDR_W-1:0] addr_q;
   logic [`AXI_ADDR_W-1:0] remain_q;
   logic [`BURST_W:0]      arlen_q;
   logic [`BURST_W+2:0]    burst_bytes;

   logic cfg_take;
   logic plan_done;
   logic burst_end;

   assign cfg_take  = cfg_valid_i && cfg_ready_o;
   // Whole burst must fit in the buffer before AR goes out
   assign plan_done = (state_q == PLAN) && (free_cnt_i >= burst_len_i);
   assign burst_end = (state_q == DATA) && r_valid_i && r_i.last;

   assign burst_bytes = {arlen_q + 1'b1, 2'b00};

   always_comb begin
      state_d = state_q;
      case (state_q)
         IDLE: begin
            if (cfg_valid_i && (cfg_i.len != '0)) begin
               state_d = PLAN;
            end
         end
         PLAN: begin
            if (plan_done) begin
               state_d = ADDR;
            end
         end
         ADDR: begin
            if (ar_ready_i) begin
               state_d = DATA;
            end
         end
         DATA: begin
            if (burst_end) begin
               state_d = (remain_q == '0) ? IDLE : PLAN;
            end
         end
         default: state_d = IDLE;
      endcase
   end

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         state_q  <= IDLE;
         remain_q <= '0;
      end else begin
         state_q <= state_d;
         if (cfg_take) begin
            remain_q <= cfg_i.len;
         end else if (plan_done) begin
            remain_q <= remain_q - burst_len_i;
         end
      end
   end

   always_ff @(posedge clk_i) begin
      if (cfg_take) begin
         addr_q <= cfg_i.addr;
      end else if (burst_end) begin
         // Next burst starts right after this one
         addr_q <= addr_q + `AXI_ADDR_W'(burst_bytes);
      end
      if (plan_done) begin
         arlen_q <= burst_len_i - 1'b1;
      end
   end

   assign cfg_ready_o = (state_q == IDLE);
   assign remain_o    = remain_q;
   assign addr_o      = addr_q;

   always_comb begin
      ar_o       = '0;
      ar_o.addr  = addr_q;
      ar_o.len   = 8'(arlen_q);
      ar_o.size  = AR_SIZE_4B;
      ar_o.burst = AR_BURST_INCR;
      ar_o.cache = AR_CACHE_DEF;
      ar_o.prot  = AR_PROT_DEF;
   end
   assign ar_valid_o = (state_q == ADDR);

   // Room was reserved in PLAN, so R is never stalled
   assign r_ready_o = (state_q == DATA);
   assign push_o    = (state_q == DATA) && r_valid_i;

   assign push_word_o.data = r_i.data;
   // Remaining length already hits zero during the final burst
   assign push_word_o.last = r_i.last && (remain_q == '0);

endmodule

// File: source/axis2axi_stream_buf.sv
// Word FIFO between the AXI side and the credit-based stream port
// Sends one word per credit returned by the consumer
`timescale 1ns/1ns
`include "axis2axi_settings.svh"

module axis2axi_stream_buf
   import axis2axi_pkg::*;
(
   input  logic                  clk_i,
   input  logic                  rst_n_i,
   input  logic                  push_i,
   input  stream_word_t          push_word_i,
   output logic [`BUF_DEPTH_W:0] free_cnt_o,
   input  logic                  credit_i,
   output logic                  out_valid_o,
   output stream_word_t          out_o
);

   localparam int unsigned DEPTH = 2 ** `BUF_DEPTH_W;
   localparam logic [`BUF_DEPTH_W:0] DEPTH_CNT = DEPTH[`BUF_DEPTH_W:0];

   stream_word_t mem_q [DEPTH];

   logic [`BUF_DEPTH_W-1:0] wr_ptr_q;
   logic [`BUF_DEPTH_W-1:0] rd_ptr_q;
   logic [`BUF_DEPTH_W:0]   count_q;
   logic [`CREDIT_W-1:0]    credit_q;
   logic                    pop;

   assign pop = (count_q != '0) && (credit_q != '0);

   always_ff @(posedge clk_i) begin
      if (push_i) begin
         mem_q[wr_ptr_q] <= push_word_i;
      end
   end

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
         count_q  <= '0;
      end else begin
         if (push_i) begin
            wr_ptr_q <= wr_ptr_q + 1'b1;
         end
         if (pop) begin
            rd_ptr_q <= rd_ptr_q + 1'b1;
         end
         case ({push_i, pop})
            2'b10:   count_q <= count_q + 1'b1;
            2'b01:   count_q <= count_q - 1'b1;
            default: count_q <= count_q;
         endcase
      end
   end

   // Credit in and word out together leave the count as is
   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         credit_q <= '0;
      end else begin
         case ({credit_i, pop})
            2'b10:   credit_q <= credit_q + 1'b1;
            2'b01:   credit_q <= credit_q - 1'b1;
            default: credit_q <= credit_q;
         endcase
      end
   end

   assign free_cnt_o  = DEPTH_CNT - count_q;
   assign out_valid_o = pop;
   assign out_o       = mem_q[rd_ptr_q];

endmodule

// File: source/axis2axi_rd_top.sv
// AXI4 read bridge top level
// Splits a config request into read bursts and streams the words out
`timescale 1ns/1ns
`include "axis2axi_settings.svh"

module axis2axi_rd_top
   import axi_rd_pkg::*;
   import axis2axi_pkg::*;
(
   input  logic         clk_i,
   input  logic         rst_n_i,
   input  logic         cfg_valid_i,
   input  cfg_req_t     cfg_i,
   output logic         cfg_ready_o,
   output axi_ar_t      ar_o,
   output logic         ar_valid_o,
   input  logic         ar_ready_i,
   input  axi_r_t       r_i,
   input  logic         r_valid_i,
   output logic         r_ready_o,
   input  logic         credit_i,
   output logic         out_valid_o,
   output stream_word_t out_o
);

   logic [`BURST_W:0]      burst_len;
   logic [`AXI_ADDR_W-1:0] remain;
   logic [`AXI_ADDR_W-1:0] addr;
   logic [`BUF_DEPTH_W:0]  free_cnt;
   logic                   buf_push;
   stream_word_t           push_word;

   axis2axi_rd_engine engine_i (
      .clk_i       (clk_i),
      .rst_n_i     (rst_n_i),
      .cfg_valid_i (cfg_valid_i),
      .cfg_i       (cfg_i),
      .cfg_ready_o (cfg_ready_o),
      .burst_len_i (burst_len),
      .remain_o    (remain),
      .addr_o      (addr),
      .free_cnt_i  (free_cnt),
      .ar_o        (ar_o),
      .ar_valid_o  (ar_valid_o),
      .ar_ready_i  (ar_ready_i),
      .r_i         (r_i),
      .r_valid_i   (r_valid_i),
      .r_ready_o   (r_ready_o),
      .push_o      (buf_push),
      .push_word_o (push_word)
   );

   axis2axi_burst_calc burst_calc_i (
      .remain_i    (remain),
      .addr_i      (addr),
      .burst_len_o (burst_len)
   );

   axis2axi_stream_buf stream_buf_i (
      .clk_i       (clk_i),
      .rst_n_i     (rst_n_i),
      .push_i      (buf_push),
      .push_word_i (push_word),
      .free_cnt_o  (free_cnt),
      .credit_i    (credit_i),
      .out_valid_o (out_valid_o),
      .out_o       (out_o)
   );

endmodule

// File: dv/axis2axi_rd_chk.sv
// Bound protocol checks for the AXI read bridge top level
// Covers AR shape and stability, R ready, credits and buffer occupancy
`timescale 1ns/1ns
`include "axis2axi_settings.svh"

module axis2axi_rd_chk
   import axi_rd_pkg::*;
(
   input logic    clk_i,
   input logic    rst_n_i,
   input axi_ar_t ar_i,
   input logic    ar_valid_i,
   input logic    ar_ready_i,
   input axi_r_t  r_i,
   input logic    r_valid_i,
   input logic    r_ready_i,
   input logic    push_i,
   input logic    credit_i,
   input logic    out_valid_i
);

   int          fail_cnt = 0;
   int          credit_bal;
   int          occupancy;
   logic        outstanding;
   logic [12:0] ar_end;

   // Byte offset in the page just past the burst
   assign ar_end = {1'b0, ar_i.addr[11:0]} + {3'b000, ar_i.len, 2'b00} + 13'd4;

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         credit_bal  <= 0;
         occupancy   <= 0;
         outstanding <= 1'b0;
      end else begin
         credit_bal <= credit_bal + int'(credit_i) - int'(out_valid_i);
         occupancy  <= occupancy + int'(push_i) - int'(out_valid_i);
         if (ar_valid_i && ar_ready_i) begin
            outstanding <= 1'b1;
         end else if (r_valid_i && r_ready_i && r_i.last) begin
            outstanding <= 1'b0;
         end
      end
   end

   a_ar_shape: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      ar_valid_i && ar_ready_i |-> ar_i.len <= 8'd7 && ar_i.size == AR_SIZE_4B &&
      ar_i.burst == AR_BURST_INCR && ar_i.id == '0 &&
      ar_i.cache == AR_CACHE_DEF && ar_i.prot == AR_PROT_DEF)
      else begin
         $error("AR burst shape out of range");
         fail_cnt++;
      end

   a_ar_page: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      ar_valid_i && ar_ready_i |-> ar_end <= 13'h1000)
      else begin
         $error("AR burst crosses a 4 KB boundary");
         fail_cnt++;
      end

   a_ar_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      ar_valid_i && !ar_ready_i |=> ar_valid_i && $stable(ar_i))
      else begin
         $error("AR request changed before ready");
         fail_cnt++;
      end

   a_r_ready: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      r_ready_i |-> outstanding)
      else begin
         $error("R ready without an outstanding burst");
         fail_cnt++;
      end

   a_credit: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      out_valid_i |-> credit_bal > 0)
      else begin
         $error("Word sent without a credit");
         fail_cnt++;
      end

   a_occupancy: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      occupancy <= (1 << `BUF_DEPTH_W))
      else begin
         $error("Stream buffer overfilled");
         fail_cnt++;
      end

endmodule

// File: dv/axis2axi_rd_tb.sv
// Testbench for the AXI read bridge with an AXI memory model and a credit consumer
// Runs directed, random, zero-length and back-pressure requests
`timescale 1ns/1ns

module axis2axi_rd_tb
   import axi_rd_pkg::*;
   import axis2axi_pkg::*;
;

   logic         clk_i = 1'b0;
   logic         rst_n_i;
   logic         cfg_valid_i;
   cfg_req_t     cfg_i;
   logic         cfg_ready_o;
   axi_ar_t      ar_o;
   logic         ar_valid_o;
   logic         ar_ready_i = 1'b0;
   axi_r_t       r_i = '0;
   logic         r_valid_i = 1'b0;
   logic         r_ready_o;
   logic         credit_i = 1'b0;
   logic         out_valid_o;
   stream_word_t out_o;

   logic [31:0]  rng_q = 32'd4;
   stream_word_t rx_q[$];
   logic [15:0]  rd_addr;
   int           beats_left;
   int           ar_wait;
   int           gap;
   int           ar_cnt = 0;
   int           credit_bal;
   int           credit_rate = 3;
   logic         hold_credits = 1'b0;
   int           data_errs = 0;
   int           to_errs = 0;

   axis2axi_rd_top dut_i (.*);

   bind axis2axi_rd_top axis2axi_rd_chk chk_i (
      .clk_i(clk_i), .rst_n_i(rst_n_i), .ar_i(ar_o), .ar_valid_i(ar_valid_o),
      .ar_ready_i(ar_ready_i), .r_i(r_i), .r_valid_i(r_valid_i), .r_ready_i(r_ready_o),
      .push_i(buf_push), .credit_i(credit_i), .out_valid_i(out_valid_o)
   );

   always #10 clk_i = ~clk_i;

   function automatic logic [31:0] next_rand();
      rng_q = rng_q ^ (rng_q << 13);
      rng_q = rng_q ^ (rng_q >> 17);
      rng_q = rng_q ^ (rng_q << 5);
      return rng_q;
   endfunction

   // Memory model serving one burst at a time with the word address as data
   always @(posedge clk_i) begin
      if (!rst_n_i) begin
         ar_ready_i <= 1'b0;
         r_valid_i  <= 1'b0;
         beats_left = 0;
         ar_wait    = 0;
         gap        = 0;
      end else begin
         if (ar_valid_o && ar_ready_i) begin
            rd_addr    = ar_o.addr;
            beats_left = int'(ar_o.len) + 1;
            gap        = next_rand() % 3;
            ar_wait    = next_rand() % 4;
            ar_cnt++;
            ar_ready_i <= 1'b0;
         end else if (ar_valid_o && beats_left == 0) begin
            if (ar_wait == 0) ar_ready_i <= 1'b1;
            else ar_wait--;
         end
         if (r_valid_i && r_ready_o) begin
            rd_addr = rd_addr + 16'd4;
            beats_left--;
            gap = next_rand() % 3;
         end
         if (!(r_valid_i && !r_ready_o)) begin
            if (beats_left != 0 && gap == 0) begin
               r_valid_i <= 1'b1;
               r_i <= '{data: 32'(rd_addr >> 2), last: (beats_left == 1), resp: 2'b00};
            end else begin
               r_valid_i <= 1'b0;
               if (gap != 0) gap--;
            end
         end
      end
   end

   // Consumer keeps at most 16 credits in flight
   always @(posedge clk_i) begin
      if (!rst_n_i) begin
         credit_i <= 1'b0;
         credit_bal = 0;
      end else begin
         credit_bal = credit_bal + int'(credit_i) - int'(out_valid_o);
         credit_i <= !hold_credits && credit_bal < 16 && (next_rand() % 4) <= credit_rate;
         if (out_valid_o) rx_q.push_back(out_o);
      end
   end

   task automatic send_cfg(input logic [15:0] addr, input logic [15:0] len);
      int n;
      n = 0;
      @(posedge clk_i);
      cfg_valid_i <= 1'b1;
      cfg_i       <= '{addr: addr, len: len};
      do begin
         @(posedge clk_i);
         n++;
      end while (!cfg_ready_o && n < 100);
      cfg_valid_i <= 1'b0;
      if (!cfg_ready_o) begin
         $display("Timeout: config at 0x%h was never accepted", addr);
         to_errs++;
      end
   endtask

   task automatic check_words(input logic [15:0] addr, input int len);
      logic [31:0] exp_data;
      exp_data = 32'(addr >> 2);
      assert (rx_q.size() == len) else begin
         $display("FAILED at %0t: %0d words received, expected %0d", $time, rx_q.size(), len);
         data_errs++;
      end
      for (int i = 0; i < rx_q.size(); i++) begin
         assert (rx_q[i].data == exp_data + i) else begin
            $display("FAILED at %0t: word %0d is 0x%h, expected 0x%h",
                     $time, i, rx_q[i].data, exp_data + i);
            data_errs++;
         end
         assert (rx_q[i].last == (i == len - 1)) else begin
            $display("FAILED at %0t: last flag wrong on word %0d", $time, i);
            data_errs++;
         end
      end
   endtask

   task automatic run_request(input logic [15:0] addr, input logic [15:0] len, input bit hold);
      int n;
      rx_q.delete();
      hold_credits = hold;
      credit_rate  = next_rand() % 4;
      send_cfg(addr, len);
      if (hold) begin
         repeat (200) @(posedge clk_i);
         @(negedge clk_i);
         hold_credits = 1'b0;
      end
      n = 0;
      do begin
         @(negedge clk_i);
         n++;
      end while (!(rx_q.size() >= len && cfg_ready_o) && n < 3000);
      if (!(rx_q.size() >= len && cfg_ready_o)) begin
         $display("Timeout: request at 0x%h did not complete", addr);
         to_errs++;
      end
      check_words(addr, len);
   endtask

   task automatic run_zero_len(input logic [15:0] addr);
      int ar_before;
      rx_q.delete();
      ar_before = ar_cnt;
      send_cfg(addr, 16'd0);
      for (int i = 0; i < 20; i++) begin
         @(negedge clk_i);
         assert (cfg_ready_o) else begin
            $display("FAILED at %0t: config ready dropped after zero length", $time);
            data_errs++;
         end
      end
      assert (ar_cnt == ar_before && rx_q.size() == 0) else begin
         $display("FAILED at %0t: zero length request produced traffic", $time);
         data_errs++;
      end
   endtask

   initial begin
      rst_n_i     = 1'b0;
      cfg_valid_i = 1'b0;
      cfg_i       = '0;
      repeat (4) @(posedge clk_i);
      rst_n_i <= 1'b1;
      @(negedge clk_i);
      run_request(16'h0100, 16'd5, 1'b0);
      // Starts 12 bytes below a page boundary
      run_request(16'h0FF4, 16'd20, 1'b0);
      run_zero_len(16'h0200);
      for (int i = 0; i < 4; i++) begin
         run_request(16'((next_rand() % 32'h3000) & ~32'h3), 16'(1 + next_rand() % 24), 1'b0);
      end
      run_request(16'h2000, 16'd40, 1'b1);
      repeat (5) @(posedge clk_i);
      $display("Errors: data %0d, timeout %0d, assertion %0d",
               data_errs, to_errs, dut_i.chk_i.fail_cnt);
      if (data_errs + to_errs + dut_i.chk_i.fail_cnt == 0) begin
         $display("Done: no errors");
      end else begin
         $display("Done: errors found");
      end
      $finish;
   end

endmodule

// File: list.f
+incdir+source
source/axi_rd_pkg.sv
source/axis2axi_pkg.sv
source/axis2axi_burst_calc.sv
source/axis2axi_rd_engine.sv
source/axis2axi_stream_buf.sv
source/axis2axi_rd_top.sv
dv/axis2axi_rd_chk.sv
dv/axis2axi_rd_tb.sv

// File: Bender.yml
package:
  name: axis2axi_rd

sources:
  - include_dirs:
      - source
    files:
      - source/axi_rd_pkg.sv
      - source/axis2axi_pkg.sv
      - source/axis2axi_burst_calc.sv
      - source/axis2axi_rd_engine.sv
      - source/axis2axi_stream_buf.sv
      - source/axis2axi_rd_top.sv
  - target: test
    include_dirs:
      - source
    files:
      - dv/axis2axi_rd_chk.sv
      - dv/axis2axi_rd_tb.sv
